// ==== project.f ====
verilog/scope_chan_pkg.sv
verilog/scope_regmap_pkg.sv
verilog/scope_bus_decode.sv
verilog/scope_ctrl_regs.sv
verilog/scope_readback.sv
verilog/scope_cfg_top.sv
testbench/tb_clk_gen.sv
testbench/tb_scope_cfg.sv

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rstn_o
);
  localparam real HALF_NS = 5.0;  // 10 ns period
  localparam int  RST_CYC = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RST_CYC) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;  // Released between edges
  end

endmodule

// ==== testbench/tb_scope_cfg.sv ====
`timescale 1ns/10ps

module tb_scope_cfg;
  import scope_chan_pkg::*;
  import scope_regmap_pkg::*;

  localparam int ACC_TIMEOUT = 20;  // Cycles to wait for one ack
  localparam int N_ACCESS    = 60;  // Bus accesses over all tests, with spare
  localparam int WATCHDOG_NS = (20 + N_ACCESS * (ACC_TIMEOUT + 4)) * 10;

  logic                    clk;
  logic                    rstn;
  logic [BUS_W-1:0]        sys_addr;
  logic [BUS_W-1:0]        sys_wdata;
  logic                    sys_wen;
  logic                    sys_ren;
  chan_status_t [N_CH-1:0] status;
  smp_t [N_CH-1:0]         bram_dat;
  logic [N_CH-1:0]         bram_ack;
  logic [BUS_W-1:0]        sys_rdata;
  logic                    sys_ack;
  chan_cfg_t [N_CH-1:0]    cfg;
  chan_cmd_t [N_CH-1:0]    cmd;
  logic                    indep_mode;

  integer seed      = 67;
  int     err_cnt   = 0;
  int     test_cnt  = 0;
  int     test_fail = 0;
  string  fname [0:3] = '{"tresh", "hyst", "dly", "dec"};

  // Reference model of the register file
  logic [31:0] m_set [0:3][0:N_CH-1];  // Masked settings by field and channel
  logic [3:0]  m_pul [0:N_CH-1];       // arm, acq_rst, trig_sw, new_trg_src
  logic        m_keep [0:N_CH-1];
  logic [3:0]  m_src [0:N_CH-1];
  logic        m_indep;

  tb_clk_gen u_clk (.clk_o(clk), .rstn_o(rstn));

  scope_cfg_top u_dut (
    .adc_clk_i     (clk),
    .adc_rstn_i    (rstn),
    .sys_addr_i    (sys_addr),
    .sys_wdata_i   (sys_wdata),
    .sys_wen_i     (sys_wen),
    .sys_ren_i     (sys_ren),
    .status_i      (status),
    .bram_rd_dat_i (bram_dat),
    .bram_ack_i    (bram_ack),
    .sys_rdata_o   (sys_rdata),
    .sys_ack_o     (sys_ack),
    .cfg_o         (cfg),
    .cmd_o         (cmd),
    .indep_mode_o  (indep_mode)
  );

  function automatic logic [31:0] ch_addr(input logic [DEC_BITS-1:0] a0, input int c);
    return 32'(a0) + ((c != 0) ? 32'(CH1_OFS) : 32'h0);
  endfunction

  function automatic logic [31:0] field_addr(input int f, input int c);
    case (f)
      0:       return (c != 0) ? 32'(ADR_TRESH1) : 32'(ADR_TRESH0);
      1:       return (c != 0) ? 32'(ADR_HYST1) : 32'(ADR_HYST0);
      2:       return ch_addr(ADR_DLY0, c);
      default: return ch_addr(ADR_DEC0, c);
    endcase
  endfunction

  function automatic logic [31:0] field_mask(input int f);
    if (f < 2)
      return 32'h0000_3FFF;
    return (f == 2) ? 32'hFFFF_FFFF : 32'h0001_FFFF;
  endfunction

  // Channel 1 takes channel 0 timing unless independent
  function automatic chan_cfg_t exp_cfg(input int c);
    int        s;
    chan_cfg_t r;
    s       = (c != 0 && !m_indep) ? 0 : c;
    r.tresh = m_set[0][c][SMP_W-1:0];
    r.hyst  = m_set[1][c][SMP_W-1:0];
    r.dly   = m_set[2][s];
    r.dec   = m_set[3][s][DEC_W-1:0];
    r.dec1  = (m_set[3][s] == 32'd1);
    return r;
  endfunction

  function automatic chan_cmd_t exp_cmd(input int c);
    int        s;
    chan_cmd_t r;
    s             = (c != 0 && !m_indep) ? 0 : c;
    r.arm         = m_pul[s][3];
    r.acq_rst     = m_pul[s][2];
    r.trig_sw     = m_pul[s][1];
    r.new_trg_src = m_pul[s][0];
    r.we_keep     = m_keep[s];
    r.trg_src     = m_src[s];
    return r;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cfg(input string what, input chan_cfg_t got, input chan_cfg_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cmd(input string what, input chan_cmd_t got, input chan_cmd_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cfgs(input string tag);
    for (int c = 0; c < N_CH; c++)
      check_cfg($sformatf("%s cfg ch%0d", tag, c), cfg[c], exp_cfg(c));
  endtask

  task automatic check_cmds(input string tag);
    for (int c = 0; c < N_CH; c++)
      check_cmd($sformatf("%s cmd ch%0d", tag, c), cmd[c], exp_cmd(c));
  endtask

  // Starts and ends right after a falling edge
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int lat);
    logic acked;
    acked     = 1'b0;
    lat       = 0;
    rdata     = '0;
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = !wr;
    while (!acked && lat < ACC_TIMEOUT) begin
      @(negedge clk);
      lat++;
      sys_wen = 1'b0;
      sys_ren = 1'b0;
      if (sys_ack) begin
        acked = 1'b1;
        rdata = sys_rdata;
      end
    end
    if (!acked) begin
      err_cnt++;
      $display("No ack came back within %0d cycles for address %h", ACC_TIMEOUT, addr);
    end
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    int          lat;
    bus_access(1'b1, addr, data, rd, lat);
    check_word($sformatf("write ack latency at %h", addr), lat, 2);
  endtask

  task automatic reg_read(input logic [31:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    int          lat;
    bus_access(1'b0, addr, '0, rd, lat);
    check_word(what, rd, exp);
    check_word($sformatf("read ack latency at %h", addr), lat, 2);
  endtask

  // Control or trigger write, checked in the cycles around the pulse
  task automatic cmd_write(input logic trig, input logic [31:0] w);
    logic [7:0] lane;
    sys_addr  = trig ? 32'(ADR_TRIG) : 32'(ADR_CTRL);
    sys_wdata = w;
    sys_wen   = 1'b1;
    @(negedge clk);
    sys_wen = 1'b0;
    check_cmds("before");
    for (int c = 0; c < N_CH; c++) begin
      lane = w[8*c +: 8];
      if (trig) begin
        m_pul[c] = {2'b00, lane == 8'h01, lane != 8'h00};
        if (lane != 8'h00)
          m_src[c] = lane[3:0];
      end else begin
        m_pul[c] = {lane[0], lane[1], 2'b00};
        if (lane != 8'h00)
          m_keep[c] = lane[3];
      end
    end
    if (!trig && w[7:0] != 8'h00)
      m_indep = w[5];
    @(negedge clk);
    check_word("command write ack", sys_ack, 1);
    check_cmds("pulse");
    for (int c = 0; c < N_CH; c++)
      m_pul[c] = '0;
    @(negedge clk);
    check_cmds("after");
    check_word("indep_mode", indep_mode, m_indep);
  endtask

  task automatic window_read(input int c, input int delay);
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] exp;
    int          lat;
    rnd          = $random(seed);
    addr         = (c + 1) << 16;
    addr[11:0]   = 12'h120;
    exp          = '0;
    exp[SMP_W-1:0] = rnd[SMP_W-1:0];
    fork
      bus_access(1'b0, addr, '0, rd, lat);
      begin
        repeat (delay) @(negedge clk);
        bram_dat[c] = rnd[SMP_W-1:0];
        bram_ack[c] = 1'b1;
        @(negedge clk);
        bram_ack[c] = 1'b0;
      end
    join
    check_word($sformatf("window data ch%0d", c), rd, exp);
    check_word($sformatf("window ack latency ch%0d", c), lat, delay + 1);
  endtask

  task automatic finish_test(input string name, input int e0);
    test_cnt++;
    if (err_cnt != e0)
      test_fail++;
    $display("Test %-9s done with %0d errors", name, err_cnt - e0);
  endtask

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    for (int c = 0; c < N_CH; c++)
      for (int f = 0; f < 4; f++)
        reg_read(field_addr(f, c), m_set[f][c], $sformatf("reset %s ch%0d", fname[f], c));
    check_cfgs("reset");
    check_cmds("reset");
    check_word("reset indep_mode", indep_mode, 0);
    finish_test("reset", e0);
  endtask

  task automatic test_settings();
    int          e0;
    logic [31:0] w;
    e0 = err_cnt;
    for (int c = 0; c < N_CH; c++)
      for (int f = 0; f < 4; f++) begin
        w = $random(seed);
        reg_write(field_addr(f, c), w);
        m_set[f][c] = w & field_mask(f);
      end
    for (int c = 0; c < N_CH; c++)
      for (int f = 0; f < 4; f++)
        reg_read(field_addr(f, c), m_set[f][c], $sformatf("%s ch%0d", fname[f], c));
    check_cfgs("merged");
    reg_write(field_addr(3, 0), 32'd1);
    m_set[3][0] = 32'd1;
    check_cfgs("dec one");
    finish_test("settings", e0);
  endtask

  task automatic test_commands();
    int e0;
    e0 = err_cnt;
    cmd_write(1'b0, 32'h0000_000B);  // Arm, reset, keep
    cmd_write(1'b1, 32'h0000_0001);  // Software trigger
    cmd_write(1'b1, 32'h0000_0705);
    cmd_write(1'b0, 32'h0000_0300);  // Channel 1 lane hidden by merge
    finish_test("commands", e0);
  endtask

  task automatic test_indep();
    int          e0;
    logic [31:0] w;
    e0 = err_cnt;
    reg_read(field_addr(2, 1), m_set[2][1], "raw dly ch1 merged");
    cmd_write(1'b0, 32'h0000_0820);  // Bit 5 sets independent mode
    check_cfgs("independent");
    cmd_write(1'b0, 32'h0000_0221);
    cmd_write(1'b1, 32'h0000_0106);
    w = $random(seed);
    reg_write(field_addr(2, 1), w);
    m_set[2][1] = w;
    check_cfgs("own dly");
    reg_read(field_addr(3, 1), m_set[3][1], "raw dec ch1");
    finish_test("indep", e0);
  endtask

  task automatic test_status();
    int          e0;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] e_adc;
    logic [31:0] e_trg;
    e0    = err_cnt;
    e_adc = '0;
    e_trg = '0;
    for (int c = 0; c < N_CH; c++) begin
      r0                  = $random(seed);
      r1                  = $random(seed);
      status[c].adc_state = r0[7:0];
      status[c].trg_state = r0[15:8];
      status[c].wp_cur    = r1[RSZ-1:0];
      status[c].wp_trig   = r1[RSZ+15:16];
      status[c].we_cnt    = $random(seed);
      e_adc[8*c +: 8]     = r0[7:0];
      e_trg[8*c +: 8]     = r0[15:8];
    end
    reg_read(32'(ADR_CTRL), e_adc, "adc state");
    reg_read(32'(ADR_TRIG), e_trg, "trigger state");
    for (int c = 0; c < N_CH; c++) begin
      reg_read(ch_addr(ADR_WPCUR0, c), 32'(status[c].wp_cur), $sformatf("wp_cur ch%0d", c));
      reg_read(ch_addr(ADR_WPTRIG0, c), 32'(status[c].wp_trig), $sformatf("wp_trig ch%0d", c));
      reg_read(ch_addr(ADR_WECNT0, c), status[c].we_cnt, $sformatf("we_cnt ch%0d", c));
    end
    reg_read(32'h0000_0040, 32'h0, "unmapped address");
    window_read(0, 3);
    window_read(1, 5);
    finish_test("status", e0);
  endtask

  initial begin
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    status    = '0;
    bram_dat  = '0;
    bram_ack  = '0;
    m_indep   = 1'b0;
    for (int c = 0; c < N_CH; c++) begin
      m_pul[c]    = '0;
      m_keep[c]   = 1'b0;
      m_src[c]    = '0;
      m_set[1][c] = 32'd20;
      m_set[2][c] = 32'd0;
      m_set[3][c] = 32'd1;
    end
    m_set[0][0] = 32'h0000_1388;  // +5000
    m_set[0][1] = 32'h0000_2C78;  // -5000 in 14 bits
    @(posedge rstn);
    @(negedge clk);
    test_reset();
    test_settings();
    test_commands();
    test_indep();
    test_status();
    $display("Tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== verilog/scope_bus_decode.sv ====
`timescale 1ns/10ps

module scope_bus_decode (
  input  logic                             adc_clk_i,
  input  logic                             adc_rstn_i,
  input  logic [scope_chan_pkg::BUS_W-1:0] sys_addr_i,
  input  logic [scope_chan_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                             sys_wen_i,
  input  logic                             sys_ren_i,
  output scope_regmap_pkg::bus_req_t       req_o
);
  import scope_chan_pkg::*;
  import scope_regmap_pkg::*;

  logic [DEC_BITS-1:0] adr;
  logic [3:0]          win_dig;
  logic [3:0]          win_idx;
  logic                in_win;
  reg_sel_e            dec_sel;
  logic                dec_chan;
  logic                wen_q;
  logic                ren_q;
  reg_sel_e            sel_q;
  logic                chan_q;
  logic [BUS_W-1:0]    wdata_q;

  assign adr     = sys_addr_i[DEC_BITS-1:0];
  assign win_dig = adr[DEC_BITS-1:DEC_BITS-4];
  assign win_idx = win_dig - 4'd1;  // 0x1xxxx is channel 0
  assign in_win  = (win_dig != 4'd0) && (win_dig <= N_CH);

  always_comb begin
    dec_chan = (adr == ADR_TRESH1) || (adr == ADR_HYST1) || ((adr & CH1_OFS) != '0);
    case (adr)
      ADR_CTRL:                           dec_sel = SEL_CTRL;
      ADR_TRIG:                           dec_sel = SEL_TRIG;
      ADR_TRESH0, ADR_TRESH1:             dec_sel = SEL_TRESH;
      ADR_HYST0, ADR_HYST1:               dec_sel = SEL_HYST;
      ADR_DLY0, ADR_DLY0 + CH1_OFS:       dec_sel = SEL_DLY;
      ADR_DEC0, ADR_DEC0 + CH1_OFS:       dec_sel = SEL_DEC;
      ADR_WPCUR0, ADR_WPCUR0 + CH1_OFS:   dec_sel = SEL_WPCUR;
      ADR_WPTRIG0, ADR_WPTRIG0 + CH1_OFS: dec_sel = SEL_WPTRIG;
      ADR_WECNT0, ADR_WECNT0 + CH1_OFS:   dec_sel = SEL_WECNT;
      default:                            dec_sel = in_win ? SEL_BRAM : SEL_NONE;
    endcase
    if (dec_sel == SEL_BRAM)
      dec_chan = win_idx[0];  // Window digit picks the buffer
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      wen_q <= 1'b0;
      ren_q <= 1'b0;
      sel_q <= SEL_NONE;
    end else begin
      wen_q <= sys_wen_i;
      ren_q <= sys_ren_i;
      sel_q <= dec_sel;   // Held window address keeps SEL_BRAM
    end
  end

  always_ff @(posedge adc_clk_i) begin
    chan_q  <= dec_chan;
    wdata_q <= sys_wdata_i;
  end

  assign req_o = '{wen: wen_q, ren: ren_q, sel: sel_q, chan: chan_q, wdata: wdata_q};

  assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    !(sys_wen_i && sys_ren_i));

endmodule

// ==== verilog/scope_cfg_top.sv ====
`timescale 1ns/10ps

module scope_cfg_top (
  input  logic                                                    adc_clk_i,
  input  logic                                                    adc_rstn_i,
  input  logic [scope_chan_pkg::BUS_W-1:0]                        sys_addr_i,
  input  logic [scope_chan_pkg::BUS_W-1:0]                        sys_wdata_i,
  input  logic                                                    sys_wen_i,
  input  logic                                                    sys_ren_i,
  input  scope_chan_pkg::chan_status_t [scope_chan_pkg::N_CH-1:0] status_i,
  input  scope_chan_pkg::smp_t         [scope_chan_pkg::N_CH-1:0] bram_rd_dat_i,
  input  logic [scope_chan_pkg::N_CH-1:0]                         bram_ack_i,
  output logic [scope_chan_pkg::BUS_W-1:0]                        sys_rdata_o,
  output logic                                                    sys_ack_o,
  output scope_chan_pkg::chan_cfg_t    [scope_chan_pkg::N_CH-1:0] cfg_o,
  output scope_chan_pkg::chan_cmd_t    [scope_chan_pkg::N_CH-1:0] cmd_o,
  output logic                                                    indep_mode_o
);
  import scope_chan_pkg::*;
  import scope_regmap_pkg::*;

  bus_req_t             req_q;    // After decode
  bus_req_t             req_d;    // After settings update
  chan_cfg_t [N_CH-1:0] raw_cfg;

  scope_bus_decode u_decode (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .req_o       (req_q)
  );

  scope_ctrl_regs u_ctrl (
    .adc_clk_i    (adc_clk_i),
    .adc_rstn_i   (adc_rstn_i),
    .req_i        (req_q),
    .req_o        (req_d),
    .raw_cfg_o    (raw_cfg),
    .cfg_o        (cfg_o),
    .cmd_o        (cmd_o),
    .indep_mode_o (indep_mode_o)
  );

  scope_readback u_readback (
    .adc_clk_i     (adc_clk_i),
    .adc_rstn_i    (adc_rstn_i),
    .req_i         (req_d),
    .raw_cfg_i     (raw_cfg),
    .status_i      (status_i),
    .bram_rd_dat_i (bram_rd_dat_i),
    .bram_ack_i    (bram_ack_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o)
  );

endmodule

// ==== verilog/scope_chan_pkg.sv ====
package scope_chan_pkg;

  localparam int N_CH  = 2;
  localparam int SMP_W = 14;   // ADC sample width
  localparam int RSZ   = 14;   // Buffer depth 2^RSZ
  localparam int DEC_W = 17;
  localparam int BUS_W = 32;

  typedef logic signed [SMP_W-1:0] smp_t;

  // Trigger settings of one channel
  typedef struct packed {
    smp_t             tresh;
    smp_t             hyst;
    logic [31:0]      dly;
    logic [DEC_W-1:0] dec;
    logic             dec1;   // Decimation is one
  } chan_cfg_t;

  typedef struct packed {
    logic       arm;          // Pulse
    logic       acq_rst;      // Pulse
    logic       trig_sw;      // Pulse
    logic       new_trg_src;  // Pulse
    logic       we_keep;      // Level
    logic [3:0] trg_src;
  } chan_cmd_t;

  // Acquisition status from the capture logic
  typedef struct packed {
    logic [7:0]     adc_state;
    logic [7:0]     trg_state;
    logic [RSZ-1:0] wp_cur;
    logic [RSZ-1:0] wp_trig;
    logic [31:0]    we_cnt;
  } chan_status_t;

endpackage

// ==== verilog/scope_ctrl_regs.sv ====
`timescale 1ns/10ps

module scope_ctrl_regs (
  input  logic                                                  adc_clk_i,
  input  logic                                                  adc_rstn_i,
  input  scope_regmap_pkg::bus_req_t                            req_i,
  output scope_regmap_pkg::bus_req_t                            req_o,
  output scope_chan_pkg::chan_cfg_t [scope_chan_pkg::N_CH-1:0]  raw_cfg_o,
  output scope_chan_pkg::chan_cfg_t [scope_chan_pkg::N_CH-1:0]  cfg_o,
  output scope_chan_pkg::chan_cmd_t [scope_chan_pkg::N_CH-1:0]  cmd_o,
  output logic                                                  indep_mode_o
);
  import scope_chan_pkg::*;
  import scope_regmap_pkg::*;

  chan_cmd_t [N_CH-1:0] cmd_raw;
  logic [4*N_CH-1:0]    pulse_all;
  logic                 indep_mode;
  logic                 wr_ctrl;
  logic                 wr_trig;
  logic                 wen_d;
  logic                 ren_d;
  reg_sel_e             sel_d;
  logic                 chan_d;
  logic [BUS_W-1:0]     wdata_d;

  assign wr_ctrl = req_i.wen && (req_i.sel == SEL_CTRL);
  assign wr_trig = req_i.wen && (req_i.sel == SEL_TRIG);

  for (genvar c = 0; c < N_CH; c++) begin : g_ch
    smp_t             tresh_q;
    smp_t             hyst_q;
    logic [31:0]      dly_q;
    logic [DEC_W-1:0] dec_q;
    chan_cmd_t        cmd_q;
    logic [7:0]       lane;
    logic             wr_set;
    logic             follow;

    assign lane   = req_i.wdata[8*c +: 8];  // Byte lane c belongs to channel c
    assign wr_set = req_i.wen && (req_i.chan == c);
    assign follow = (c != 0) && !indep_mode;

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        tresh_q <= (c == 0) ? RST_TRESH0 : RST_TRESH1;
        hyst_q  <= RST_HYST;
        dly_q   <= RST_DLY;
        dec_q   <= RST_DEC;
      end else if (wr_set) begin
        case (req_i.sel)
          SEL_TRESH: tresh_q <= req_i.wdata[SMP_W-1:0];
          SEL_HYST:  hyst_q  <= req_i.wdata[SMP_W-1:0];
          SEL_DLY:   dly_q   <= req_i.wdata[31:0];
          SEL_DEC:   dec_q   <= req_i.wdata[DEC_W-1:0];
          default:   ;
        endcase
      end
    end

    always_ff @(posedge adc_clk_i) begin
      if (!adc_rstn_i) begin
        cmd_q <= '0;
      end else begin
        cmd_q.arm         <= wr_ctrl && lane[0];
        cmd_q.acq_rst     <= wr_ctrl && lane[1];
        cmd_q.trig_sw     <= wr_trig && (lane[3:0] == 4'h1);  // Software source
        cmd_q.new_trg_src <= wr_trig && (lane != 8'h0);
        if (wr_ctrl && (lane != 8'h0))
          cmd_q.we_keep <= lane[3];
        if (wr_trig && (lane != 8'h0))
          cmd_q.trg_src <= lane[3:0];
      end
    end

    assign raw_cfg_o[c] = '{tresh: tresh_q, hyst: hyst_q, dly: dly_q, dec: dec_q,
                            dec1: (dec_q == DEC_W'(1))};
    assign cmd_raw[c]   = cmd_q;
    assign pulse_all[4*c +: 4] = {cmd_q.arm, cmd_q.acq_rst, cmd_q.trig_sw, cmd_q.new_trg_src};

    // Threshold and hysteresis stay per channel
    assign cfg_o[c] = follow ? chan_cfg_t'{tresh: tresh_q, hyst: hyst_q, dly: raw_cfg_o[0].dly,
                                           dec: raw_cfg_o[0].dec, dec1: raw_cfg_o[0].dec1}
                             : raw_cfg_o[c];
    assign cmd_o[c] = follow ? cmd_raw[0] : cmd_raw[c];
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      indep_mode <= 1'b0;
    end else if (wr_ctrl && (req_i.wdata[7:0] != 8'h0)) begin
      indep_mode <= req_i.wdata[5];
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      wen_d <= 1'b0;
      ren_d <= 1'b0;
      sel_d <= SEL_NONE;
    end else begin
      wen_d <= req_i.wen;
      ren_d <= req_i.ren;
      sel_d <= req_i.sel;
    end
  end

  always_ff @(posedge adc_clk_i) begin
    chan_d  <= req_i.chan;
    wdata_d <= req_i.wdata;
  end

  assign req_o        = '{wen: wen_d, ren: ren_d, sel: sel_d, chan: chan_d, wdata: wdata_d};
  assign indep_mode_o = indep_mode;

  // Every command pulse lasts one cycle
  assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    (|pulse_all) |=> ((pulse_all & $past(pulse_all)) == '0));

endmodule

// ==== verilog/scope_readback.sv ====
`timescale 1ns/10ps

module scope_readback (
  input  logic                                                    adc_clk_i,
  input  logic                                                    adc_rstn_i,
  input  scope_regmap_pkg::bus_req_t                              req_i,
  input  scope_chan_pkg::chan_cfg_t    [scope_chan_pkg::N_CH-1:0] raw_cfg_i,
  input  scope_chan_pkg::chan_status_t [scope_chan_pkg::N_CH-1:0] status_i,
  input  scope_chan_pkg::smp_t         [scope_chan_pkg::N_CH-1:0] bram_rd_dat_i,
  input  logic [scope_chan_pkg::N_CH-1:0]                         bram_ack_i,
  output logic [scope_chan_pkg::BUS_W-1:0]                        sys_rdata_o,
  output logic                                                    sys_ack_o
);
  import scope_chan_pkg::*;
  import scope_regmap_pkg::*;

  chan_cfg_t        cfg_sel;
  chan_status_t     st_sel;
  logic [BUS_W-1:0] reg_rdata;
  logic             reg_ack;
  logic             win_req;
  logic             win_busy;
  logic             win_open;
  logic             bram_hit;
  logic             bram_ack_q;
  logic [BUS_W-1:0] bram_dat_q;

  assign cfg_sel  = raw_cfg_i[req_i.chan];
  assign st_sel   = status_i[req_i.chan];
  assign win_req  = req_i.ren && (req_i.sel == SEL_BRAM);
  assign win_open = win_busy || win_req;
  assign bram_hit = win_open && (req_i.sel == SEL_BRAM) && bram_ack_i[req_i.chan];
  assign reg_ack  = req_i.wen || (req_i.ren && (req_i.sel != SEL_BRAM));

  always_comb begin
    reg_rdata = '0;
    case (req_i.sel)
      SEL_CTRL: begin
        for (int c = 0; c < N_CH; c++)
          reg_rdata[8*c +: 8] = status_i[c].adc_state;
      end
      SEL_TRIG: begin
        for (int c = 0; c < N_CH; c++)
          reg_rdata[8*c +: 8] = status_i[c].trg_state;
      end
      SEL_TRESH:  reg_rdata[SMP_W-1:0] = cfg_sel.tresh;  // Raw pattern, no sign fill
      SEL_HYST:   reg_rdata[SMP_W-1:0] = cfg_sel.hyst;
      SEL_DLY:    reg_rdata            = cfg_sel.dly;
      SEL_DEC:    reg_rdata[DEC_W-1:0] = cfg_sel.dec;
      SEL_WPCUR:  reg_rdata[RSZ-1:0]   = st_sel.wp_cur;
      SEL_WPTRIG: reg_rdata[RSZ-1:0]   = st_sel.wp_trig;
      SEL_WECNT:  reg_rdata            = st_sel.we_cnt;
      default:    reg_rdata            = '0;
    endcase
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      win_busy   <= 1'b0;
      bram_ack_q <= 1'b0;
    end else begin
      bram_ack_q <= bram_hit;
      if (bram_hit)
        win_busy <= 1'b0;
      else if (win_req)
        win_busy <= 1'b1;  // Wait for the buffer ack
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (bram_hit)
      bram_dat_q <= {{(BUS_W-SMP_W){1'b0}}, bram_rd_dat_i[req_i.chan]};
  end

  assign sys_ack_o   = reg_ack || bram_ack_q;
  assign sys_rdata_o = bram_ack_q ? bram_dat_q : reg_rdata;

  // Window ack only while the window address is still held
  assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    sys_ack_o |-> (req_i.wen || req_i.ren || (req_i.sel == SEL_BRAM)));

endmodule

// ==== verilog/scope_regmap_pkg.sv ====
package scope_regmap_pkg;

  localparam int DEC_BITS = 20;  // Address bits seen by the decoder

  localparam logic [DEC_BITS-1:0] ADR_CTRL    = 20'h00000;
  localparam logic [DEC_BITS-1:0] ADR_TRIG    = 20'h00004;
  localparam logic [DEC_BITS-1:0] ADR_TRESH0  = 20'h00008;
  localparam logic [DEC_BITS-1:0] ADR_TRESH1  = 20'h0000C;
  localparam logic [DEC_BITS-1:0] ADR_DLY0    = 20'h00010;
  localparam logic [DEC_BITS-1:0] ADR_DEC0    = 20'h00014;
  localparam logic [DEC_BITS-1:0] ADR_WPCUR0  = 20'h00018;
  localparam logic [DEC_BITS-1:0] ADR_WPTRIG0 = 20'h0001C;
  localparam logic [DEC_BITS-1:0] ADR_HYST0   = 20'h00020;
  localparam logic [DEC_BITS-1:0] ADR_HYST1   = 20'h00024;
  localparam logic [DEC_BITS-1:0] ADR_WECNT0  = 20'h0002C;
  localparam logic [DEC_BITS-1:0] CH1_OFS     = 20'h00100;  // Channel 1 copy of dly..wecnt

  localparam scope_chan_pkg::smp_t RST_TRESH0 = 14'sd5000;
  localparam scope_chan_pkg::smp_t RST_TRESH1 = -14'sd5000;
  localparam scope_chan_pkg::smp_t RST_HYST   = 14'sd20;
  localparam logic [31:0]          RST_DLY    = 32'd0;

  localparam logic [scope_chan_pkg::DEC_W-1:0] RST_DEC = 1;

  typedef enum logic [3:0] {
    SEL_CTRL, SEL_TRIG,
    SEL_TRESH, SEL_HYST, SEL_DLY, SEL_DEC,
    SEL_WPCUR, SEL_WPTRIG, SEL_WECNT,
    SEL_BRAM,
    SEL_NONE
  } reg_sel_e;

  // Bus request after address decode
  typedef struct packed {
    logic                             wen;
    logic                             ren;
    reg_sel_e                         sel;
    logic                             chan;
    logic [scope_chan_pkg::BUS_W-1:0] wdata;
  } bus_req_t;

endpackage
